//--- common/radio_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Radio control package
// Settings bus format, register map and shared control types
////////////////////////////////////////////////////////////

`default_nettype none

package radio_ctrl_pkg;

   // Settings bus widths
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // Master time width used by the top level unless overridden
   localparam int TIME_W_DEFAULT = 32;

   // Register field widths
   localparam int CLK_CTRL_W = 5;
   localparam int SER_CTRL_W = 4;
   localparam int ADC_CTRL_W = 4;
   localparam int LED_W      = 8;

   // Interrupt sources
   localparam int IRQ_W      = 3;
   localparam int IRQ_PPS    = 0;
   localparam int IRQ_PHY    = 1;
   localparam int IRQ_LOADED = 2;

   ////////////////////////////////////////////////////////////
   // Setting addresses
   localparam logic [SET_ADDR_W-1:0] SR_CLK       = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_SER       = 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_ADC       = 8'd2;
   localparam logic [SET_ADDR_W-1:0] SR_LED       = 8'd3;
   localparam logic [SET_ADDR_W-1:0] SR_PHY       = 8'd4;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_LOAD = 8'd5;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_CTRL = 8'd6;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SRC   = 8'd8;
   localparam logic [SET_ADDR_W-1:0] SR_IRQ_MASK  = 8'd9;
   localparam logic [SET_ADDR_W-1:0] SR_IRQ_CLEAR = 8'd10;

   ////////////////////////////////////////////////////////////
   // Shared types

   // One settings write, valid for a single cycle while stb is high
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   // Board control registers
   typedef struct packed {
      logic [CLK_CTRL_W-1:0] clk_ctrl;
      logic [SER_CTRL_W-1:0] ser_ctrl;
      logic [ADC_CTRL_W-1:0] adc_ctrl;
      logic [LED_W-1:0]      led_sw;
      logic [LED_W-1:0]      led_src;
      logic                  phy_reset;
   } ctrl_regs_t;

   // Timekeeper controls, load value sized for the widest master time
   typedef struct packed {
      logic [TIME_W_DEFAULT-1:0] load_value;
      logic                      load_req;
      logic                      pps_neg_sel;
   } time_cmd_t;

   // Interrupt controller controls
   typedef struct packed {
      logic [IRQ_W-1:0] mask;
      logic [IRQ_W-1:0] clear;
      logic             clear_stb;
   } irq_cmd_t;

endpackage

`default_nettype wire

//--- design/settings/setting_bank.sv
////////////////////////////////////////////////////////////
// Setting bank
// Decodes settings writes into control registers and pulses
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module setting_bank
   import radio_ctrl_pkg::*;
#(
   parameter int TIME_W = TIME_W_DEFAULT
) (
   input  logic       dsp_clk,
   input  logic       arst_n_i,
   input  set_bus_t   set_i,
   output ctrl_regs_t regs_o,
   output time_cmd_t  time_cmd_o,
   output irq_cmd_t   irq_cmd_o
);

   ctrl_regs_t        regs_q;
   logic [TIME_W-1:0] time_load_q;
   logic              load_req_q;
   logic              pps_neg_sel_q;
   logic [IRQ_W-1:0]  irq_mask_q;
   logic [IRQ_W-1:0]  irq_clear_q;
   logic              clear_stb_q;

   ////////////////////////////////////////////////////////////
   // Register writes
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         regs_q        <= '0;
         time_load_q   <= '0;
         load_req_q    <= 1'b0;
         pps_neg_sel_q <= 1'b0;
         irq_mask_q    <= '0;
         irq_clear_q   <= '0;
         clear_stb_q   <= 1'b0;
      end else begin
         // Pulses last one cycle after the strobe
         load_req_q  <= 1'b0;
         clear_stb_q <= 1'b0;
         if (set_i.stb) begin
            case (set_i.addr)
               SR_CLK:       regs_q.clk_ctrl  <= set_i.data[CLK_CTRL_W-1:0];
               SR_SER:       regs_q.ser_ctrl  <= set_i.data[SER_CTRL_W-1:0];
               SR_ADC:       regs_q.adc_ctrl  <= set_i.data[ADC_CTRL_W-1:0];
               SR_LED:       regs_q.led_sw    <= set_i.data[LED_W-1:0];
               SR_PHY:       regs_q.phy_reset <= set_i.data[0];
               SR_LED_SRC:   regs_q.led_src   <= set_i.data[LED_W-1:0];
               SR_TIME_CTRL: pps_neg_sel_q    <= set_i.data[0];
               SR_IRQ_MASK:  irq_mask_q       <= set_i.data[IRQ_W-1:0];
               SR_TIME_LOAD: begin
                  time_load_q <= set_i.data[TIME_W-1:0];
                  load_req_q  <= 1'b1;
               end
               SR_IRQ_CLEAR: begin
                  irq_clear_q <= set_i.data[IRQ_W-1:0];
                  clear_stb_q <= 1'b1;
               end
               // Unknown addresses fall through untouched
               default: ;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Outputs to the consumers
   assign regs_o = regs_q;

   // Load value widened to the package field
   assign time_cmd_o.load_value  = TIME_W_DEFAULT'(time_load_q);
   assign time_cmd_o.load_req    = load_req_q;
   assign time_cmd_o.pps_neg_sel = pps_neg_sel_q;

   assign irq_cmd_o.mask      = irq_mask_q;
   assign irq_cmd_o.clear     = irq_clear_q;
   assign irq_cmd_o.clear_stb = clear_stb_q;

endmodule

`default_nettype wire

//--- design/board_ctrl.sv
////////////////////////////////////////////////////////////
// Board control
// Control pins, status synchronizers and LED source mux
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module board_ctrl
   import radio_ctrl_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       arst_n_i,
   input  ctrl_regs_t regs_i,
   input  logic       serdes_link_up_i,
   input  logic       clk_status_i,
   input  logic       phy_int_n_i,
   output logic       clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic       ser_enable_o,
   output logic       ser_prbsen_o,
   output logic       ser_loopen_o,
   output logic       ser_rx_en_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_b_o,
   output logic       adc_oe_b_o,
   output logic       phy_reset_n_o,
   output logic [7:0] leds_o,
   output logic       phy_int_o
);

   // Status order is {phy_int, clk_status, link_up}
   logic [2:0]       status_meta;
   logic [2:0]       status_sync;
   logic [LED_W-1:0] led_hw;

   ////////////////////////////////////////////////////////////
   // Two flop synchronizer
   // PHY interrupt inverted first so reset leaves it inactive
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         status_meta <= '0;
         status_sync <= '0;
      end else begin
         status_meta <= {~phy_int_n_i, clk_status_i, serdes_link_up_i};
         status_sync <= status_meta;
      end
   end

   assign phy_int_o = status_sync[2];

   ////////////////////////////////////////////////////////////
   // Control pins
   assign {clock_ready_o, clk_en_o, clk_sel_o} = regs_i.clk_ctrl;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = regs_i.ser_ctrl;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = regs_i.adc_ctrl;

   // PHY reset pin is active low
   assign phy_reset_n_o = ~regs_i.phy_reset;

   ////////////////////////////////////////////////////////////
   // LEDs, a set led_src bit hands the LED to hardware
   assign led_hw = {6'b0, status_sync[1:0]};
   assign leds_o = (regs_i.led_src & led_hw) | (~regs_i.led_src & regs_i.led_sw);

endmodule

`default_nettype wire

//--- design/timekeeper/timekeeper.sv
////////////////////////////////////////////////////////////
// Timekeeper
// Master time counter with PPS capture and armed time load
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module timekeeper
   import radio_ctrl_pkg::*;
#(
   parameter int TIME_W = TIME_W_DEFAULT
) (
   input  logic              dsp_clk,
   input  logic              arst_n_i,
   input  logic              pps_i,
   input  time_cmd_t         time_cmd_i,
   output logic [TIME_W-1:0] master_time_o,
   output logic [TIME_W-1:0] pps_time_o,
   output logic              pps_evt_o,
   output logic              loaded_evt_o
);

   logic pps_pos_smp;
   logic pps_neg_smp;
   logic pps_smp;
   logic pps_dly;
   logic pps_edge;
   logic load_armed;

   ////////////////////////////////////////////////////////////
   // PPS sampling on both clock edges
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pps_pos_smp <= 1'b0;
      end else begin
         pps_pos_smp <= pps_i;
      end
   end

   // Negedge sample sees PPS half a cycle sooner
   always_ff @(negedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pps_neg_smp <= 1'b0;
      end else begin
         pps_neg_smp <= pps_i;
      end
   end

   assign pps_smp = time_cmd_i.pps_neg_sel ? pps_neg_smp : pps_pos_smp;

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pps_dly <= 1'b0;
      end else begin
         pps_dly <= pps_smp;
      end
   end

   // Rising edge of the selected sample
   assign pps_edge = pps_smp & ~pps_dly;

   ////////////////////////////////////////////////////////////
   // Master time, load arm and edge capture
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         master_time_o <= '0;
         pps_time_o    <= '0;
         load_armed    <= 1'b0;
         pps_evt_o     <= 1'b0;
         loaded_evt_o  <= 1'b0;
      end else begin
         pps_evt_o    <= pps_edge;
         loaded_evt_o <= 1'b0;
         if (pps_edge) begin
            pps_time_o <= master_time_o;
         end
         if (pps_edge && load_armed) begin
            master_time_o <= time_cmd_i.load_value[TIME_W-1:0];
            load_armed    <= 1'b0;
            loaded_evt_o  <= 1'b1;
         end else begin
            master_time_o <= master_time_o + 1'b1;
         end
         // A fresh request re-arms for the following edge
         if (time_cmd_i.load_req) begin
            load_armed <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/irq_ctrl.sv
////////////////////////////////////////////////////////////
// Interrupt controller
// Sticky pending bits with mask, write-one-to-clear
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module irq_ctrl
   import radio_ctrl_pkg::*;
(
   input  logic             dsp_clk,
   input  logic             arst_n_i,
   input  irq_cmd_t         irq_cmd_i,
   input  logic             pps_evt_i,
   input  logic             loaded_evt_i,
   input  logic             phy_int_i,
   output logic             irq_o,
   output logic [IRQ_W-1:0] irq_pending_o
);

   logic [IRQ_W-1:0] irq_set;
   logic [IRQ_W-1:0] irq_clr;
   logic [IRQ_W-1:0] pending_q;

   ////////////////////////////////////////////////////////////
   // Source mapping
   always_comb begin
      irq_set             = '0;
      irq_set[IRQ_PPS]    = pps_evt_i;
      irq_set[IRQ_PHY]    = phy_int_i;
      irq_set[IRQ_LOADED] = loaded_evt_i;
   end

   // Clear bits only count while the strobe is up
   assign irq_clr = irq_cmd_i.clear_stb ? irq_cmd_i.clear : '0;

   ////////////////////////////////////////////////////////////
   // Pending bits, set wins over clear
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pending_q <= '0;
      end else begin
         pending_q <= (pending_q & ~irq_clr) | irq_set;
      end
   end

   // Registered interrupt line
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         irq_o <= 1'b0;
      end else begin
         irq_o <= |(pending_q & irq_cmd_i.mask);
      end
   end

   assign irq_pending_o = pending_q;

endmodule

`default_nettype wire

//--- design/radio_ctrl_top.sv
////////////////////////////////////////////////////////////
// Radio control top
// Settings decode feeding board, time and interrupt blocks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_top
   import radio_ctrl_pkg::*;
#(
   parameter int TIME_W = TIME_W_DEFAULT
) (
   input  logic              dsp_clk,
   input  logic              arst_n_i,
   input  set_bus_t          set_i,
   // Board status
   input  logic              serdes_link_up_i,
   input  logic              clk_status_i,
   input  logic              phy_int_n_i,
   input  logic              pps_i,
   // Board control pins
   output logic              clock_ready_o,
   output logic [1:0]        clk_en_o,
   output logic [1:0]        clk_sel_o,
   output logic              ser_enable_o,
   output logic              ser_prbsen_o,
   output logic              ser_loopen_o,
   output logic              ser_rx_en_o,
   output logic              adc_on_a_o,
   output logic              adc_oe_a_o,
   output logic              adc_on_b_o,
   output logic              adc_oe_b_o,
   output logic              phy_reset_n_o,
   output logic [7:0]        leds_o,
   // Time and interrupts
   output logic [TIME_W-1:0] master_time_o,
   output logic [TIME_W-1:0] pps_time_o,
   output logic              irq_o,
   output logic [IRQ_W-1:0]  irq_pending_o
);

   ctrl_regs_t ctrl_regs;
   time_cmd_t  time_cmd;
   irq_cmd_t   irq_cmd;
   logic       pps_evt;
   logic       loaded_evt;
   logic       phy_int;

   ////////////////////////////////////////////////////////////
   // Settings decode
   setting_bank #(
      .TIME_W (TIME_W)
   ) u_setting_bank (
      .dsp_clk    (dsp_clk),
      .arst_n_i   (arst_n_i),
      .set_i      (set_i),
      .regs_o     (ctrl_regs),
      .time_cmd_o (time_cmd),
      .irq_cmd_o  (irq_cmd)
   );

   ////////////////////////////////////////////////////////////
   // Consumers
   board_ctrl u_board_ctrl (
      .dsp_clk          (dsp_clk),
      .arst_n_i         (arst_n_i),
      .regs_i           (ctrl_regs),
      .serdes_link_up_i (serdes_link_up_i),
      .clk_status_i     (clk_status_i),
      .phy_int_n_i      (phy_int_n_i),
      .clock_ready_o    (clock_ready_o),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_enable_o     (ser_enable_o),
      .ser_prbsen_o     (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),
      .ser_rx_en_o      (ser_rx_en_o),
      .adc_on_a_o       (adc_on_a_o),
      .adc_oe_a_o       (adc_oe_a_o),
      .adc_on_b_o       (adc_on_b_o),
      .adc_oe_b_o       (adc_oe_b_o),
      .phy_reset_n_o    (phy_reset_n_o),
      .leds_o           (leds_o),
      .phy_int_o        (phy_int)
   );

   timekeeper #(
      .TIME_W (TIME_W)
   ) u_timekeeper (
      .dsp_clk       (dsp_clk),
      .arst_n_i      (arst_n_i),
      .pps_i         (pps_i),
      .time_cmd_i    (time_cmd),
      .master_time_o (master_time_o),
      .pps_time_o    (pps_time_o),
      .pps_evt_o     (pps_evt),
      .loaded_evt_o  (loaded_evt)
   );

   irq_ctrl u_irq_ctrl (
      .dsp_clk       (dsp_clk),
      .arst_n_i      (arst_n_i),
      .irq_cmd_i     (irq_cmd),
      .pps_evt_i     (pps_evt),
      .loaded_evt_i  (loaded_evt),
      .phy_int_i     (phy_int),
      .irq_o         (irq_o),
      .irq_pending_o (irq_pending_o)
   );

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset
// 8 ns dsp_clk, reset held low for two cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter real PERIOD_NS    = 8.0,
   parameter int  RESET_CYCLES = 2
) (
   output logic dsp_clk_o,
   output logic arst_n_o
);

   initial begin
      dsp_clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0);
         dsp_clk_o = ~dsp_clk_o;
      end
   end

   // Release lands just after a rising edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge dsp_clk_o);
      #1;
      arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

//--- sim/tb_radio_ctrl.sv
////////////////////////////////////////////////////////////
// Radio control testbench
// Directed tests of settings, LEDs, time keeping and interrupts
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_radio_ctrl
   import radio_ctrl_pkg::*;
();

   localparam int TIME_W = TIME_W_DEFAULT;
   // Tests take under 300 cycles, so this leaves a wide margin
   localparam int CYCLE_LIMIT = 2000;

   logic              dsp_clk;
   logic              arst_n;
   set_bus_t          set_bus;
   logic              serdes_link_up;
   logic              clk_status;
   logic              phy_int_n;
   logic              pps;
   logic              clock_ready;
   logic [1:0]        clk_en;
   logic [1:0]        clk_sel;
   logic              ser_enable;
   logic              ser_prbsen;
   logic              ser_loopen;
   logic              ser_rx_en;
   logic              adc_on_a;
   logic              adc_oe_a;
   logic              adc_on_b;
   logic              adc_oe_b;
   logic              phy_reset_n;
   logic [7:0]        leds;
   logic [TIME_W-1:0] master_time;
   logic [TIME_W-1:0] pps_time;
   logic              irq;
   logic [IRQ_W-1:0]  irq_pending;

   integer seed        = 32'h3852d7b4;
   int     error_count = 0;
   int     check_count = 0;
   int     tests_run   = 0;
   int     cycle_count = 0;

   tb_clk_gen u_clk_gen (
      .dsp_clk_o (dsp_clk),
      .arst_n_o  (arst_n)
   );

   radio_ctrl_top #(
      .TIME_W (TIME_W)
   ) uut (
      .dsp_clk          (dsp_clk),
      .arst_n_i         (arst_n),
      .set_i            (set_bus),
      .serdes_link_up_i (serdes_link_up),
      .clk_status_i     (clk_status),
      .phy_int_n_i      (phy_int_n),
      .pps_i            (pps),
      .clock_ready_o    (clock_ready),
      .clk_en_o         (clk_en),
      .clk_sel_o        (clk_sel),
      .ser_enable_o     (ser_enable),
      .ser_prbsen_o     (ser_prbsen),
      .ser_loopen_o     (ser_loopen),
      .ser_rx_en_o      (ser_rx_en),
      .adc_on_a_o       (adc_on_a),
      .adc_oe_a_o       (adc_oe_a),
      .adc_on_b_o       (adc_on_b),
      .adc_oe_b_o       (adc_oe_b),
      .phy_reset_n_o    (phy_reset_n),
      .leds_o           (leds),
      .master_time_o    (master_time),
      .pps_time_o       (pps_time),
      .irq_o            (irq),
      .irq_pending_o    (irq_pending)
   );

   ////////////////////////////////////////////////////////////
   // Helpers

   // Each step ends 1 ns after a rising edge
   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge dsp_clk);
         #1;
      end
   endtask

   task automatic set_write(input logic [7:0] addr, input logic [31:0] data);
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      wait_cycles(1);
      set_bus      = '0;
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (error_count == errors_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, error_count - errors_before);
      end
   endtask

   function automatic logic [31:0] control_pins();
      return {clock_ready, clk_en, clk_sel, ser_enable, ser_prbsen, ser_loopen, ser_rx_en,
              adc_on_a, adc_oe_a, adc_on_b, adc_oe_b, phy_reset_n, leds};
   endfunction

   ////////////////////////////////////////////////////////////
   // Tests

   task automatic reset_state_test();
      int errors_before;
      errors_before = error_count;
      check("clk pins", {clock_ready, clk_en, clk_sel}, 0);
      check("ser pins", {ser_enable, ser_prbsen, ser_loopen, ser_rx_en}, 0);
      check("adc pins", {adc_on_a, adc_oe_a, adc_on_b, adc_oe_b}, 0);
      check("phy_reset_n_o", phy_reset_n, 1);
      check("irq_o", irq, 0);
      check("leds_o", leds, 0);
      check("pps_time_o", pps_time, 0);
      report_test("reset state", errors_before);
   endtask

   task automatic register_test();
      int          errors_before;
      logic [31:0] data;
      logic [31:0] pins_before;
      errors_before = error_count;
      repeat (4) begin
         data = $random(seed);
         set_write(SR_CLK, data);
         check("clk pins", {clock_ready, clk_en, clk_sel}, data[4:0]);
         data = $random(seed);
         set_write(SR_SER, data);
         check("ser pins", {ser_enable, ser_prbsen, ser_loopen, ser_rx_en}, data[3:0]);
         data = $random(seed);
         set_write(SR_ADC, data);
         check("adc pins", {adc_oe_a, adc_on_a, adc_oe_b, adc_on_b}, data[3:0]);
         data = $random(seed);
         set_write(SR_PHY, data);
         check("phy_reset_n_o", phy_reset_n, !data[0]);
      end
      // Address 7 and the top of the map hold no register
      pins_before = control_pins();
      set_write(8'd7, $random(seed));
      set_write(8'hf0, $random(seed));
      check("pins after unused writes", control_pins(), pins_before);
      report_test("register writes", errors_before);
   endtask

   task automatic led_test();
      int         errors_before;
      int         i;
      logic [7:0] sw;
      logic [7:0] src;
      logic [7:0] hw;
      logic [7:0] expected;
      errors_before = error_count;
      repeat (8) begin
         sw             = $random(seed);
         src            = $random(seed);
         serdes_link_up = $random(seed);
         clk_status     = $random(seed);
         set_write(SR_LED, {24'b0, sw});
         set_write(SR_LED_SRC, {24'b0, src});
         wait_cycles(3);
         hw = {6'b0, clk_status, serdes_link_up};
         // Hardware owns the LED where its source bit is set
         for (i = 0; i < 8; i++) begin
            expected[i] = src[i] ? hw[i] : sw[i];
         end
         check("leds_o", leds, expected);
      end
      report_test("LED mux", errors_before);
   endtask

   task automatic master_time_test();
      int                errors_before;
      int                n;
      logic [TIME_W-1:0] start;
      errors_before = error_count;
      start = master_time;
      n     = 40 + ($random(seed) & 31);
      wait_cycles(n);
      check("master_time_o", master_time, TIME_W'(start + n));
      report_test("master time", errors_before);
   endtask

   task automatic armed_load_test(input bit neg_mode);
      int                errors_before;
      int                latency;
      int                k;
      logic [TIME_W-1:0] load_value;
      logic [TIME_W-1:0] before_edge;
      logic [TIME_W-1:0] at_raise;
      string             name;
      errors_before = error_count;
      // Negedge sample sees PPS half a cycle sooner
      latency    = neg_mode ? 1 : 2;
      name       = neg_mode ? "armed load, negedge PPS" : "armed load, posedge PPS";
      load_value = $random(seed);
      set_write(SR_TIME_CTRL, {31'b0, neg_mode});
      set_write(SR_TIME_LOAD, load_value);
      // Load is armed one cycle after the write
      wait_cycles(1);
      pps = 1'b1;
      wait_cycles(latency - 1);
      before_edge = master_time;
      wait_cycles(1);
      check("master_time_o", master_time, load_value);
      check("pps_time_o", pps_time, before_edge);
      k = 1 + ($random(seed) & 15);
      wait_cycles(k);
      check("master_time_o", master_time, TIME_W'(load_value + k));

      // Second edge, nothing armed
      pps = 1'b0;
      wait_cycles(3);
      pps      = 1'b1;
      at_raise = master_time;
      wait_cycles(latency - 1);
      before_edge = master_time;
      wait_cycles(1);
      check("master_time_o", master_time, TIME_W'(at_raise + latency));
      check("pps_time_o", pps_time, before_edge);
      pps = 1'b0;
      wait_cycles(2);
      set_write(SR_TIME_CTRL, 32'd0);
      report_test(name, errors_before);
   endtask

   task automatic irq_test();
      int errors_before;
      errors_before = error_count;
      // Edges and loads of the time tests left their bits pending
      check("irq_pending_o", irq_pending, (32'd1 << IRQ_PPS) | (32'd1 << IRQ_LOADED));
      set_write(SR_IRQ_MASK, 32'd0);
      set_write(SR_IRQ_CLEAR, 32'h7);
      wait_cycles(1);
      check("irq_pending_o", irq_pending, 0);

      // PPS edge with all sources masked
      pps = 1'b1;
      wait_cycles(4);
      pps = 1'b0;
      check("irq_pending_o", irq_pending, 32'd1 << IRQ_PPS);
      check("irq_o", irq, 0);
      set_write(SR_IRQ_MASK, 32'd1 << IRQ_PPS);
      check("irq_o", irq, 0);
      wait_cycles(1);
      check("irq_o", irq, 1);
      set_write(SR_IRQ_CLEAR, 32'd1 << IRQ_PPS);
      wait_cycles(2);
      check("irq_o", irq, 0);
      check("irq_pending_o", irq_pending, 0);

      // PHY level keeps its bit while held
      set_write(SR_IRQ_MASK, 32'd1 << IRQ_PHY);
      phy_int_n = 1'b0;
      wait_cycles(5);
      check("irq_pending_o", irq_pending, 32'd1 << IRQ_PHY);
      check("irq_o", irq, 1);
      set_write(SR_IRQ_CLEAR, 32'd1 << IRQ_PHY);
      wait_cycles(2);
      check("irq_pending_o", irq_pending, 32'd1 << IRQ_PHY);
      check("irq_o", irq, 1);
      phy_int_n = 1'b1;
      wait_cycles(4);
      set_write(SR_IRQ_CLEAR, 32'd1 << IRQ_PHY);
      wait_cycles(2);
      check("irq_pending_o", irq_pending, 0);
      check("irq_o", irq, 0);
      report_test("interrupts", errors_before);
   endtask

   ////////////////////////////////////////////////////////////
   // Run limit
   always @(posedge dsp_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
         $display("Regression failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      set_bus        = '0;
      serdes_link_up = 1'b0;
      clk_status     = 1'b0;
      phy_int_n      = 1'b1;
      pps            = 1'b0;
      wait (arst_n === 1'b1);
      wait_cycles(1);

      reset_state_test();
      register_test();
      led_test();
      master_time_test();
      armed_load_test(1'b0);
      armed_load_test(1'b1);
      irq_test();

      $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
      if (error_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
common/radio_ctrl_pkg.sv
design/settings/setting_bank.sv
design/board_ctrl.sv
design/timekeeper/timekeeper.sv
design/irq_ctrl.sv
design/radio_ctrl_top.sv
sim/tb_clk_gen.sv
sim/tb_radio_ctrl.sv

//--- Bender.yml
package:
  name: radio_ctrl

sources:
  - common/radio_ctrl_pkg.sv
  - design/settings/setting_bank.sv
  - design/board_ctrl.sv
  - design/timekeeper/timekeeper.sv
  - design/irq_ctrl.sv
  - design/radio_ctrl_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_radio_ctrl.sv
